// ==== hw/mvm_pkg.sv ====
`default_nettype none

package mvm_pkg;

	typedef logic [11:0] addr_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0] count_t;
	typedef logic [7:0] elem_pair_t;
	typedef logic [15:0] prod_t;
	typedef logic [16:0] sum_t;

	// header values for bits per element
	typedef enum logic [3:0] {
		PREC_2 = 4'd2,
		PREC_4 = 4'd4,
		PREC_8 = 4'd8
	} prec_t;

	typedef enum logic [2:0] {
		LANE_OFF = 3'd0,
		L2_0     = 3'd1,
		L2_1     = 3'd2,
		L2_2     = 3'd3,
		L2_3     = 3'd4,
		L4_0     = 3'd5,
		L4_1     = 3'd6,
		L8_0     = 3'd7
	} lane_sel_t;

	typedef enum logic [1:0] {
		ADDR_HOLD,
		ADDR_STEP,
		ADDR_REWIND,
		ADDR_CLEAR
	} addr_op_t;

	// size word that ends a run
	localparam count_t SIZE_END = 8'hff;

endpackage

`default_nettype wire

// ==== hw/mvm_lane_unpack.sv ====
`default_nettype none
`timescale 1ns/1ps

module mvm_lane_unpack (
	input  mvm_pkg::word_t        word,
	input  mvm_pkg::lane_sel_t    lane_sel,
	output mvm_pkg::elem_pair_t   elem_lo,
	output mvm_pkg::elem_pair_t   elem_hi
);

	// elements are unsigned, zero extended to the multiplier width
	always_comb
	begin
		case (lane_sel)
			mvm_pkg::L2_0:
			begin
				elem_lo = {6'd0, word[1:0]};
				elem_hi = {6'd0, word[3:2]};
			end
			mvm_pkg::L2_1:
			begin
				elem_lo = {6'd0, word[5:4]};
				elem_hi = {6'd0, word[7:6]};
			end
			mvm_pkg::L2_2:
			begin
				elem_lo = {6'd0, word[9:8]};
				elem_hi = {6'd0, word[11:10]};
			end
			mvm_pkg::L2_3:
			begin
				elem_lo = {6'd0, word[13:12]};
				elem_hi = {6'd0, word[15:14]};
			end
			mvm_pkg::L4_0:
			begin
				elem_lo = {4'd0, word[3:0]};
				elem_hi = {4'd0, word[7:4]};
			end
			mvm_pkg::L4_1:
			begin
				elem_lo = {4'd0, word[11:8]};
				elem_hi = {4'd0, word[15:12]};
			end
			mvm_pkg::L8_0:
			begin
				elem_lo = word[7:0];
				elem_hi = word[15:8];
			end
			default:
			begin
				elem_lo = '0;
				elem_hi = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/mvm_mac_pipeline.sv ====
`default_nettype none
`timescale 1ns/1ps

module mvm_mac_pipeline (
	input  logic                  clk,
	input  logic                  reset_b,
	input  mvm_pkg::word_t        in_word,
	input  mvm_pkg::word_t        wt_word,
	input  mvm_pkg::lane_sel_t    lane_sel,
	input  logic                  accumulate,
	input  logic                  write_en,
	input  mvm_pkg::addr_t        wr_addr_in,
	output mvm_pkg::addr_t        out_wr_addr,
	output mvm_pkg::word_t        out_wr_data,
	output logic                  out_wr_en
);

	mvm_pkg::word_t in_s1;
	mvm_pkg::word_t wt_s1;
	mvm_pkg::lane_sel_t sel_s1;
	logic acc_s1;
	logic wen_s1;
	mvm_pkg::addr_t addr_s1;
	mvm_pkg::elem_pair_t in_lo;
	mvm_pkg::elem_pair_t in_hi;
	mvm_pkg::elem_pair_t wt_lo;
	mvm_pkg::elem_pair_t wt_hi;
	mvm_pkg::prod_t prod_lo_s2;
	mvm_pkg::prod_t prod_hi_s2;
	logic acc_s2;
	logic wen_s2;
	mvm_pkg::addr_t addr_s2;
	mvm_pkg::word_t feedback;
	mvm_pkg::sum_t sum;
	mvm_pkg::sum_t sum_s3;
	logic wen_s3;
	mvm_pkg::addr_t addr_s3;

	mvm_lane_unpack i_in_unpack (
		.word     (in_s1),
		.lane_sel (sel_s1),
		.elem_lo  (in_lo),
		.elem_hi  (in_hi)
	);

	mvm_lane_unpack i_wt_unpack (
		.word     (wt_s1),
		.lane_sel (sel_s1),
		.elem_lo  (wt_lo),
		.elem_hi  (wt_hi)
	);

	// running row sum wraps at 16 bits
	assign feedback = acc_s2 ? sum_s3[15:0] : '0;
	assign sum = {1'b0, prod_lo_s2} + {1'b0, prod_hi_s2} + {1'b0, feedback};

	always_ff @(posedge clk)
	begin
		in_s1 <= in_word;
		wt_s1 <= wt_word;
		prod_lo_s2 <= in_lo * wt_lo;
		prod_hi_s2 <= in_hi * wt_hi;
		sum_s3 <= sum;
	end

	// address and strobe travel with their pair
	always_ff @(posedge clk)
	begin
		if (!reset_b)
		begin
			sel_s1 <= mvm_pkg::LANE_OFF;
			{acc_s1, wen_s1, acc_s2, wen_s2, wen_s3} <= '0;
			{addr_s1, addr_s2, addr_s3} <= '0;
		end
		else
		begin
			sel_s1 <= lane_sel;
			acc_s1 <= accumulate;
			wen_s1 <= write_en;
			addr_s1 <= wr_addr_in;
			acc_s2 <= acc_s1;
			wen_s2 <= wen_s1;
			addr_s2 <= addr_s1;
			wen_s3 <= wen_s2;
			addr_s3 <= addr_s2;
		end
	end

	assign out_wr_addr = addr_s3;
	assign out_wr_data = sum_s3[15:0];
	assign out_wr_en = wen_s3;

endmodule

`default_nettype wire

// ==== hw/mvm_address_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module mvm_address_gen (
	input  logic                 clk,
	input  logic                 reset_b,
	input  mvm_pkg::addr_op_t    in_addr_op,
	input  mvm_pkg::addr_op_t    wt_addr_op,
	input  mvm_pkg::addr_op_t    out_addr_op,
	input  mvm_pkg::addr_t       rewind_words,
	output mvm_pkg::addr_t       in_rd_addr,
	output mvm_pkg::addr_t       wt_rd_addr,
	output mvm_pkg::addr_t       out_wr_addr
);

	mvm_pkg::addr_t in_reg;
	mvm_pkg::addr_t wt_reg;
	mvm_pkg::addr_t out_reg;
	mvm_pkg::addr_t in_next;
	mvm_pkg::addr_t wt_next;
	mvm_pkg::addr_t out_next;

	function automatic mvm_pkg::addr_t next_addr(input mvm_pkg::addr_t cur,
			input mvm_pkg::addr_op_t op, input mvm_pkg::addr_t back);
		case (op)
			mvm_pkg::ADDR_STEP: next_addr = cur + 12'd1;
			mvm_pkg::ADDR_REWIND: next_addr = cur + 12'd1 - back;
			mvm_pkg::ADDR_CLEAR: next_addr = '0;
			default: next_addr = cur;
		endcase
	endfunction

	// only the input side ever rewinds
	assign in_next = next_addr(in_reg, in_addr_op, rewind_words);
	assign wt_next = next_addr(wt_reg, wt_addr_op, '0);
	assign out_next = next_addr(out_reg, out_addr_op, '0);

	// read ports see the next value so the data arrives with the register
	assign in_rd_addr = in_next;
	assign wt_rd_addr = wt_next;
	assign out_wr_addr = out_reg;

	always_ff @(posedge clk)
	begin
		if (!reset_b)
		begin
			in_reg <= '0;
			wt_reg <= '0;
			out_reg <= '0;
		end
		else
		begin
			in_reg <= in_next;
			wt_reg <= wt_next;
			out_reg <= out_next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mvm_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module mvm_sequencer (
	input  logic                  clk,
	input  logic                  reset_b,
	input  logic                  run,
	input  mvm_pkg::word_t        in_rd_data,
	output logic                  busy,
	output mvm_pkg::addr_op_t     in_addr_op,
	output mvm_pkg::addr_op_t     wt_addr_op,
	output mvm_pkg::addr_op_t     out_addr_op,
	output mvm_pkg::addr_t        rewind_words,
	output mvm_pkg::lane_sel_t    lane_sel,
	output logic                  accumulate,
	output logic                  write_en
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_SIZE,
		S_PREC,
		S_LANE,
		S_DRAIN1,
		S_DRAIN2
	} seq_state_t;

	seq_state_t state;
	seq_state_t next_state;
	mvm_pkg::count_t n_size;
	mvm_pkg::prec_t prec;
	mvm_pkg::count_t col_cnt;
	mvm_pkg::count_t row_cnt;
	logic [1:0] lane_idx;
	logic [1:0] last_lane;
	logic [1:0] word_shift;
	mvm_pkg::lane_sel_t pair_sel;
	logic first_pair;
	logic last_pair;
	logic last_row;

	// lanes per word and words per vector follow the precision
	always_comb
	begin
		case (prec)
			mvm_pkg::PREC_2:
			begin
				last_lane = 2'd3;
				word_shift = 2'd3;
				case (lane_idx)
					2'd0: pair_sel = mvm_pkg::L2_0;
					2'd1: pair_sel = mvm_pkg::L2_1;
					2'd2: pair_sel = mvm_pkg::L2_2;
					default: pair_sel = mvm_pkg::L2_3;
				endcase
			end
			mvm_pkg::PREC_4:
			begin
				last_lane = 2'd1;
				word_shift = 2'd2;
				pair_sel = lane_idx[0] ? mvm_pkg::L4_1 : mvm_pkg::L4_0;
			end
			default:
			begin
				last_lane = 2'd0;
				word_shift = 2'd1;
				pair_sel = mvm_pkg::L8_0;
			end
		endcase
	end

	assign rewind_words = {4'd0, n_size >> word_shift};
	assign first_pair = (col_cnt == 8'd0);
	assign last_pair = (col_cnt == n_size - 8'd2);
	assign last_row = (row_cnt == n_size - 8'd1);

	always_comb
	begin
		next_state = state;
		in_addr_op = mvm_pkg::ADDR_HOLD;
		wt_addr_op = mvm_pkg::ADDR_HOLD;
		out_addr_op = mvm_pkg::ADDR_HOLD;
		lane_sel = mvm_pkg::LANE_OFF;
		accumulate = 1'b0;
		write_en = 1'b0;
		case (state)
			S_IDLE:
			begin
				if (run)
				begin
					in_addr_op = mvm_pkg::ADDR_CLEAR;
					wt_addr_op = mvm_pkg::ADDR_CLEAR;
					out_addr_op = mvm_pkg::ADDR_CLEAR;
					next_state = S_SIZE;
				end
			end
			S_SIZE:
			begin
				if (in_rd_data[7:0] == mvm_pkg::SIZE_END)
					next_state = S_DRAIN1;
				else
				begin
					in_addr_op = mvm_pkg::ADDR_STEP;
					next_state = S_PREC;
				end
			end
			S_PREC:
			begin
				in_addr_op = mvm_pkg::ADDR_STEP;
				next_state = S_LANE;
			end
			S_LANE:
			begin
				lane_sel = pair_sel;
				accumulate = !first_pair;
				write_en = last_pair;
				if (lane_idx == last_lane)
				begin
					in_addr_op = mvm_pkg::ADDR_STEP;
					wt_addr_op = mvm_pkg::ADDR_STEP;
				end
				if (last_pair)
				begin
					out_addr_op = mvm_pkg::ADDR_STEP;
					// after the last row the input address runs on to the next header
					if (last_row)
						next_state = S_SIZE;
					else
						in_addr_op = mvm_pkg::ADDR_REWIND;
				end
			end
			// let the last row leave the pipeline
			S_DRAIN1: next_state = S_DRAIN2;
			S_DRAIN2: next_state = S_IDLE;
			default: next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset_b)
		begin
			state <= S_IDLE;
			busy <= 1'b0;
			n_size <= '0;
			prec <= mvm_pkg::PREC_8;
			col_cnt <= '0;
			row_cnt <= '0;
			lane_idx <= 2'd0;
		end
		else
		begin
			state <= next_state;
			busy <= (next_state != S_IDLE);
			if (state == S_SIZE)
				n_size <= in_rd_data[7:0];
			if (state == S_PREC)
			begin
				prec <= mvm_pkg::prec_t'(in_rd_data[3:0]);
				col_cnt <= '0;
				row_cnt <= '0;
				lane_idx <= 2'd0;
			end
			if (state == S_LANE)
			begin
				lane_idx <= (lane_idx == last_lane) ? 2'd0 : lane_idx + 2'd1;
				if (last_pair)
				begin
					col_cnt <= '0;
					row_cnt <= row_cnt + 8'd1;
				end
				else
					col_cnt <= col_cnt + 8'd2;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/mvm_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module mvm_top (
	input  logic                clk,
	input  logic                reset_b,
	input  logic                run,
	output logic                busy,
	output mvm_pkg::addr_t      in_rd_addr,
	input  mvm_pkg::word_t      in_rd_data,
	output mvm_pkg::addr_t      wt_rd_addr,
	input  mvm_pkg::word_t      wt_rd_data,
	output mvm_pkg::addr_t      out_wr_addr,
	output mvm_pkg::word_t      out_wr_data,
	output logic                out_wr_en
);

	mvm_pkg::addr_op_t in_addr_op;
	mvm_pkg::addr_op_t wt_addr_op;
	mvm_pkg::addr_op_t out_addr_op;
	mvm_pkg::addr_t rewind_words;
	mvm_pkg::addr_t row_addr;
	mvm_pkg::lane_sel_t lane_sel;
	logic accumulate;
	logic write_en;

	mvm_sequencer i_mvm_sequencer (
		.clk          (clk),
		.reset_b      (reset_b),
		.run          (run),
		.in_rd_data   (in_rd_data),
		.busy         (busy),
		.in_addr_op   (in_addr_op),
		.wt_addr_op   (wt_addr_op),
		.out_addr_op  (out_addr_op),
		.rewind_words (rewind_words),
		.lane_sel     (lane_sel),
		.accumulate   (accumulate),
		.write_en     (write_en)
	);

	mvm_address_gen i_mvm_address_gen (
		.clk          (clk),
		.reset_b      (reset_b),
		.in_addr_op   (in_addr_op),
		.wt_addr_op   (wt_addr_op),
		.out_addr_op  (out_addr_op),
		.rewind_words (rewind_words),
		.in_rd_addr   (in_rd_addr),
		.wt_rd_addr   (wt_rd_addr),
		.out_wr_addr  (row_addr)
	);

	// memory data lines up with the lane controls of the same cycle
	mvm_mac_pipeline i_mvm_mac_pipeline (
		.clk         (clk),
		.reset_b     (reset_b),
		.in_word     (in_rd_data),
		.wt_word     (wt_rd_data),
		.lane_sel    (lane_sel),
		.accumulate  (accumulate),
		.write_en    (write_en),
		.wr_addr_in  (row_addr),
		.out_wr_addr (out_wr_addr),
		.out_wr_data (out_wr_data),
		.out_wr_en   (out_wr_en)
	);

endmodule

`default_nettype wire

// ==== tb/tb_mvm_tests.svh ====
`ifndef TB_MVM_TESTS_SVH
`define TB_MVM_TESTS_SVH

// every address bit changes the background word
task automatic fill_memories();
	int a;
	for (a = 0; a < 4096; a++)
	begin
		in_mem[mvm_pkg::addr_t'(a)] = mvm_pkg::word_t'(a * 40503 + 4661);
		wt_mem[mvm_pkg::addr_t'(a)] = mvm_pkg::word_t'(a * 25173 + 13849);
	end
	in_ptr = 0;
	wt_ptr = 0;
	exp_q.delete();
endtask

// header, packed vector, weight rows and the expected row sums
task automatic add_job(input int n, input int bits, input bit all_ones);
	int per_word;
	int words;
	int mask;
	int acc;
	int wt_elem;
	int i;
	int j;
	int r;
	int vec [$];
	mvm_pkg::word_t packed_word;
	per_word = 16 / bits;
	words = n / per_word;
	mask = (1 << bits) - 1;
	in_mem[mvm_pkg::addr_t'(in_ptr)] = mvm_pkg::word_t'(n);
	in_mem[mvm_pkg::addr_t'(in_ptr + 1)] = mvm_pkg::word_t'(bits);
	for (i = 0; i < n; i++)
		vec.push_back(all_ones ? mask : ($random(seed) & mask));
	for (i = 0; i < words; i++)
	begin
		packed_word = '0;
		for (j = 0; j < per_word; j++)
			packed_word = packed_word | mvm_pkg::word_t'(vec[i * per_word + j] << (j * bits));
		in_mem[mvm_pkg::addr_t'(in_ptr + 2 + i)] = packed_word;
	end
	in_ptr = in_ptr + 2 + words;
	for (r = 0; r < n; r++)
	begin
		acc = 0;
		for (i = 0; i < words; i++)
		begin
			packed_word = '0;
			for (j = 0; j < per_word; j++)
			begin
				wt_elem = all_ones ? mask : ($random(seed) & mask);
				acc = acc + vec[i * per_word + j] * wt_elem;
				packed_word = packed_word | mvm_pkg::word_t'(wt_elem << (j * bits));
			end
			wt_mem[mvm_pkg::addr_t'(wt_ptr + i)] = packed_word;
		end
		wt_ptr = wt_ptr + words;
		// row sum wraps at 16 bits
		exp_q.push_back(mvm_pkg::word_t'(acc));
	end
endtask

task automatic run_jobs();
	int cycles;
	@(posedge clk);
	run <= 1'b1;
	@(posedge clk);
	run <= 1'b0;
	@(negedge clk);
	if (!busy)
	begin
		error_count++;
		$display("t=%0t busy did not rise one cycle after run", $time);
	end
	cycles = 0;
	while (busy && cycles < RUN_TIMEOUT)
	begin
		@(negedge clk);
		cycles++;
	end
	if (busy)
	begin
		error_count++;
		$display("t=%0t timeout, busy still high after %0d cycles", $time, RUN_TIMEOUT);
	end
endtask

task automatic run_and_check();
	int base;
	int i;
	in_mem[mvm_pkg::addr_t'(in_ptr)] = {8'h00, mvm_pkg::SIZE_END};
	base = wr_count;
	run_jobs();
	check_addr("write count", mvm_pkg::addr_t'(wr_count - base),
		mvm_pkg::addr_t'(exp_q.size()));
	for (i = 0; i < exp_q.size(); i++)
	begin
		if (base + i < wr_count)
		begin
			check_addr($sformatf("out_wr_addr[%0d]", i), log_addr[base + i],
				mvm_pkg::addr_t'(i));
			check_word($sformatf("out_wr_data[%0d]", i), log_data[base + i], exp_q[i]);
		end
	end
endtask

task automatic idle_quiet();
	int base;
	int i;
	$display("test: idle after reset");
	base = wr_count;
	for (i = 0; i < 20; i++)
	begin
		@(negedge clk);
		if (busy || out_wr_en)
		begin
			error_count++;
			$display("t=%0t busy or write strobe high while run is low", $time);
		end
	end
	check_addr("idle write count", mvm_pkg::addr_t'(wr_count - base), '0);
endtask

task automatic single_8bit_job();
	$display("test: 8-bit job, N = 2");
	fill_memories();
	add_job(2, 8, 1'b0);
	run_and_check();
endtask

task automatic random_4bit_job();
	$display("test: 4-bit job, N = 4");
	fill_memories();
	add_job(4, 4, 1'b0);
	run_and_check();
endtask

task automatic random_2bit_job();
	$display("test: 2-bit job, N = 8");
	fill_memories();
	add_job(8, 2, 1'b0);
	run_and_check();
endtask

task automatic back_to_back_jobs();
	$display("test: three jobs at 8, 2 and 4 bits");
	fill_memories();
	add_job(4, 8, 1'b0);
	add_job(8, 2, 1'b0);
	add_job(4, 4, 1'b0);
	run_and_check();
	// any write after the fall of busy shows up here
	repeat (4) @(negedge clk);
	check_addr("writes while busy low", mvm_pkg::addr_t'(late_writes), '0);
endtask

task automatic all_ones_wrap();
	$display("test: 8-bit job, N = 8, all elements 255");
	fill_memories();
	add_job(8, 8, 1'b1);
	run_and_check();
endtask

`endif

// ==== tb/tb_mvm.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_mvm;

	localparam int RUN_TIMEOUT = 2000;

	logic clk = 1'b0;
	logic reset_b;
	logic run;
	logic busy;
	mvm_pkg::addr_t in_rd_addr;
	mvm_pkg::word_t in_rd_data = '0;
	mvm_pkg::addr_t wt_rd_addr;
	mvm_pkg::word_t wt_rd_data = '0;
	mvm_pkg::addr_t out_wr_addr;
	mvm_pkg::word_t out_wr_data;
	logic out_wr_en;

	mvm_pkg::word_t in_mem [4096];
	mvm_pkg::word_t wt_mem [4096];
	mvm_pkg::addr_t log_addr [$];
	mvm_pkg::word_t log_data [$];
	mvm_pkg::word_t exp_q [$];
	int wr_count = 0;
	int late_writes = 0;
	int error_count = 0;
	int check_count = 0;
	int seed = 32'h3d47_089e;
	int in_ptr;
	int wt_ptr;

	mvm_top i_mvm_top (
		.clk         (clk),
		.reset_b     (reset_b),
		.run         (run),
		.busy        (busy),
		.in_rd_addr  (in_rd_addr),
		.in_rd_data  (in_rd_data),
		.wt_rd_addr  (wt_rd_addr),
		.wt_rd_data  (wt_rd_data),
		.out_wr_addr (out_wr_addr),
		.out_wr_data (out_wr_data),
		.out_wr_en   (out_wr_en)
	);

	always #50 clk = ~clk;

	// synchronous memories, one cycle read latency
	always @(posedge clk)
	begin
		in_rd_data <= in_mem[in_rd_addr];
		wt_rd_data <= wt_mem[wt_rd_addr];
	end

	// write capture in arrival order
	always @(posedge clk)
	begin
		if (reset_b && out_wr_en)
		begin
			log_addr.push_back(out_wr_addr);
			log_data.push_back(out_wr_data);
			wr_count++;
			if (!busy)
				late_writes++;
		end
	end

	task automatic check_word(input string name, input mvm_pkg::word_t got,
			input mvm_pkg::word_t exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input mvm_pkg::addr_t got,
			input mvm_pkg::addr_t exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	initial
	begin
		reset_b = 1'b0;
		run = 1'b0;
		repeat (2) @(posedge clk);
		reset_b <= 1'b1;
		@(negedge clk);
		idle_quiet();
		single_8bit_job();
		random_4bit_job();
		random_2bit_job();
		back_to_back_jobs();
		all_ones_wrap();
		$display("errors: %0d  checks: %0d", error_count, check_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	`include "tb_mvm_tests.svh"

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tb
hw/mvm_pkg.sv
hw/mvm_lane_unpack.sv
hw/mvm_mac_pipeline.sv
hw/mvm_address_gen.sv
hw/mvm_sequencer.sv
hw/mvm_top.sv
tb/tb_mvm.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-Mdir obj_dir --top-module tb_mvm -o tb_mvm \
	-f sim.f

./obj_dir/tb_mvm | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
